/* hdl/pcie_rx_params.svh */
// ======================================================================
// Width and position macros for the PCIe receive engine
// Data bus, user word, lane and header field sizes
// ======================================================================

`ifndef PCIE_RX_PARAMS_SVH
`define PCIE_RX_PARAMS_SVH

// Receive stream from the hard core
`define PCIE_RX_DATA_W       128
`define PCIE_RX_USER_W       22
`define PCIE_RX_DW_W         32   // One lane, one dword

// Start-of-frame flags in the user word
`define PCIE_RX_SOF_BIT      14
`define PCIE_RX_SOF_MID_BIT  13   // Start in lane 2

// Header fields
`define PCIE_RX_ADDR_W       13   // Dword address, DW2 bits 14 to 2
`define PCIE_RX_LEN_W        10
`define PCIE_RX_BE_W         8    // First and last byte enables

`endif

/* hdl/pcie_tlp_pkg.sv */
// ======================================================================
// TLP level types
// Format/type codes of the supported requests and the start position
// of a TLP inside the 128-bit beat
// ======================================================================

package pcie_tlp_pkg;

    // Format/type field of DW0, bits 30 to 24
    // Only the 32-bit memory requests are handled, all others are dropped
    typedef enum logic [6:0] {
        MEM_RD32 = 7'h00,   // 3DW header, no data
        MEM_WR32 = 7'h40    // 3DW header, with data
    } tlp_op_e;

    // Lane where DW0 of a TLP sits
    typedef enum logic {
        SOF_RIGHT = 1'b0,   // Lane 0, whole request in one beat
        SOF_MID   = 1'b1    // Lane 2, DW2 and data follow in the next beat
    } sof_pos_e;

endpackage

/* hdl/pcie_rx_pkg.sv */
// ======================================================================
// Receive engine types
// Control FSM states and the decoded kind of a receive beat
// ======================================================================

package pcie_rx_pkg;

    typedef enum logic [1:0] {
        IDLE,       // Accepting new TLPs
        RD_CONT,    // Waiting for second beat of a mid-start read
        WR_CONT,    // Waiting for second beat of a mid-start write
        WAIT        // Request out, waiting on sink or completion engine
    } rx_state_e;

    // NONE also covers unsupported opcodes and length other than 1
    typedef enum logic [2:0] {
        NONE,
        RD_RIGHT,
        WR_RIGHT,
        RD_MID,
        WR_MID
    } beat_kind_e;

endpackage

/* hdl/tlp_hdr_decode.sv */
// ======================================================================
// Receive beat decoder
// Start position, opcode and length check, header field extraction
// ======================================================================

`timescale 1ns/100ps

`include "pcie_rx_params.svh"

module tlp_hdr_decode
    import pcie_tlp_pkg::*;
    import pcie_rx_pkg::*;
(
    input  logic [`PCIE_RX_DATA_W-1:0] rx_tdata,
    input  logic [`PCIE_RX_USER_W-1:0] rx_tuser,
    input  logic                       cont_beat,
    output beat_kind_e                 beat_kind,
    output logic [2:0]                 tc,
    output logic                       td,
    output logic                       ep,
    output logic [1:0]                 attr,
    output logic [`PCIE_RX_LEN_W-1:0]  len,
    output logic [15:0]                rid,
    output logic [7:0]                 tag,
    output logic [`PCIE_RX_BE_W-1:0]   be,
    output logic [`PCIE_RX_ADDR_W-1:0] addr,
    output logic [`PCIE_RX_DW_W-1:0]   wdata
);

    localparam int LANES = `PCIE_RX_DATA_W / `PCIE_RX_DW_W;

    logic [`PCIE_RX_DW_W-1:0] lane [LANES];
    logic                     sof_present;
    sof_pos_e                 sof_pos;
    logic [`PCIE_RX_DW_W-1:0] dw0;
    logic [`PCIE_RX_DW_W-1:0] dw1;
    logic [`PCIE_RX_DW_W-1:0] addr_dw;
    logic [6:0]               fmt_type;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane[i] = rx_tdata[i*`PCIE_RX_DW_W +: `PCIE_RX_DW_W];
        end
    end

    assign sof_present = rx_tuser[`PCIE_RX_SOF_BIT];
    assign sof_pos     = rx_tuser[`PCIE_RX_SOF_MID_BIT] ? SOF_MID : SOF_RIGHT;

    // Header dwords move up by two lanes on a mid start
    assign dw0 = (sof_pos == SOF_MID) ? lane[2] : lane[0];
    assign dw1 = (sof_pos == SOF_MID) ? lane[3] : lane[1];

    // Second beat of a mid start carries DW2 and data in the low lanes
    assign addr_dw = cont_beat ? lane[0] : lane[2];
    assign wdata   = cont_beat ? lane[1] : lane[3];
    assign addr    = addr_dw[`PCIE_RX_ADDR_W+1:2];

    assign fmt_type = dw0[30:24];
    assign tc       = dw0[22:20];
    assign td       = dw0[15];
    assign ep       = dw0[14];
    assign attr     = dw0[13:12];
    assign len      = dw0[`PCIE_RX_LEN_W-1:0];
    assign rid      = dw1[31:16];
    assign tag      = dw1[15:8];
    assign be       = dw1[`PCIE_RX_BE_W-1:0];

    always_comb begin
        beat_kind = NONE;
        if (sof_present && !cont_beat && len == `PCIE_RX_LEN_W'(1)) begin
            case (fmt_type)
                MEM_RD32: beat_kind = (sof_pos == SOF_MID) ? RD_MID : RD_RIGHT;
                MEM_WR32: beat_kind = (sof_pos == SOF_MID) ? WR_MID : WR_RIGHT;
                default:  beat_kind = NONE;   // Anything else is dropped
            endcase
        end
    end

endmodule

/* hdl/rx_ctrl.sv */
// ======================================================================
// Receive control FSM
// Registered ready, header load and issue strobes per accepted beat,
// hold-off until the write sink or completion engine is free
// ======================================================================

`timescale 1ns/100ps

module rx_ctrl
    import pcie_rx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       rx_tvalid,
    input  beat_kind_e beat_kind,
    input  logic       wr_busy,
    input  logic       compl_done,
    output logic       rx_tready,
    output logic       hdr_load,
    output logic       rd_issue,
    output logic       wr_issue,
    output logic       cont_beat
);

    rx_state_e state;
    rx_state_e state_next;
    logic      ready_next;
    logic      wait_wr;         // Kind held in WAIT, 1 for a write
    logic      wait_wr_next;
    logic      accept;

    assign accept    = rx_tvalid && rx_tready;
    assign cont_beat = (state == RD_CONT) || (state == WR_CONT);

    // Strobes are qualified by the handshake so the output registers
    // sample the beat on the same edge that accepts it
    always_comb begin
        state_next   = state;
        ready_next   = rx_tready;
        wait_wr_next = wait_wr;
        hdr_load     = 1'b0;
        rd_issue     = 1'b0;
        wr_issue     = 1'b0;

        case (state)
            IDLE: begin
                ready_next = 1'b1;
                if (accept) begin
                    case (beat_kind)
                        RD_RIGHT: begin
                            hdr_load     = 1'b1;
                            rd_issue     = 1'b1;
                            wait_wr_next = 1'b0;
                            ready_next   = 1'b0;
                            state_next   = WAIT;
                        end
                        WR_RIGHT: begin
                            hdr_load     = 1'b1;
                            wr_issue     = 1'b1;
                            wait_wr_next = 1'b1;
                            ready_next   = 1'b0;
                            state_next   = WAIT;
                        end
                        RD_MID: begin
                            hdr_load   = 1'b1;
                            state_next = RD_CONT;   // Ready stays high
                        end
                        WR_MID: begin
                            hdr_load   = 1'b1;
                            state_next = WR_CONT;
                        end
                        default: state_next = IDLE;   // Discarded beat
                    endcase
                end
            end

            RD_CONT, WR_CONT: begin
                if (accept) begin
                    rd_issue     = (state == RD_CONT);
                    wr_issue     = (state == WR_CONT);
                    wait_wr_next = (state == WR_CONT);
                    ready_next   = 1'b0;
                    state_next   = WAIT;
                end
            end

            WAIT: begin
                ready_next = 1'b0;
                if (wait_wr ? !wr_busy : compl_done) begin
                    ready_next = 1'b1;
                    state_next = IDLE;
                end
            end

            default: begin
                ready_next = 1'b0;
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state     <= IDLE;
            rx_tready <= 1'b0;
            wait_wr   <= 1'b0;
        end else begin
            state     <= state_next;
            rx_tready <= ready_next;
            wait_wr   <= wait_wr_next;
        end
    end

endmodule

/* hdl/cpl_req_reg.sv */
// ======================================================================
// Completion request register
// Holds requester header fields and read address, pulses req_compl
// ======================================================================

`timescale 1ns/100ps

`include "pcie_rx_params.svh"

module cpl_req_reg (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       hdr_load,
    input  logic                       rd_issue,
    input  logic [2:0]                 tc,
    input  logic                       td,
    input  logic                       ep,
    input  logic [1:0]                 attr,
    input  logic [`PCIE_RX_LEN_W-1:0]  len,
    input  logic [15:0]                rid,
    input  logic [7:0]                 tag,
    input  logic [`PCIE_RX_BE_W-1:0]   be,
    input  logic [`PCIE_RX_ADDR_W-1:0] addr,
    output logic                       req_compl,
    output logic                       req_compl_wd,
    output logic [2:0]                 req_tc,
    output logic                       req_td,
    output logic                       req_ep,
    output logic [1:0]                 req_attr,
    output logic [`PCIE_RX_LEN_W-1:0]  req_len,
    output logic [15:0]                req_rid,
    output logic [7:0]                 req_tag,
    output logic [`PCIE_RX_BE_W-1:0]   req_be,
    output logic [`PCIE_RX_ADDR_W-1:0] req_addr
);

    // Header of a mid start arrives one or more beats before the address
    always_ff @(posedge i_clk) begin
        if (hdr_load) begin
            req_tc   <= tc;
            req_td   <= td;
            req_ep   <= ep;
            req_attr <= attr;
            req_len  <= len;
            req_rid  <= rid;
            req_tag  <= tag;
            req_be   <= be;
        end
        if (rd_issue) begin
            req_addr <= addr;
        end
    end

    // Completion with data, so both strobes fire together
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            req_compl    <= 1'b0;
            req_compl_wd <= 1'b0;
        end else begin
            req_compl    <= rd_issue;
            req_compl_wd <= rd_issue;
        end
    end

endmodule

/* hdl/mem_wr_reg.sv */
// ======================================================================
// Memory write register
// Holds write address, data and byte enables, pulses wr_en
// ======================================================================

`timescale 1ns/100ps

`include "pcie_rx_params.svh"

module mem_wr_reg (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       hdr_load,
    input  logic                       wr_issue,
    input  logic [`PCIE_RX_BE_W-1:0]   be,
    input  logic [`PCIE_RX_ADDR_W-1:0] addr,
    input  logic [`PCIE_RX_DW_W-1:0]   wdata,
    output logic                       wr_en,
    output logic [`PCIE_RX_ADDR_W-1:0] wr_addr,
    output logic [`PCIE_RX_DW_W-1:0]   wr_data,
    output logic [`PCIE_RX_BE_W-1:0]   wr_be
);

    // Byte enables come with DW1, address and data with DW2 and DW3
    always_ff @(posedge i_clk) begin
        if (hdr_load) begin
            wr_be <= be;
        end
        if (wr_issue) begin
            wr_addr <= addr;
            wr_data <= wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= wr_issue;   // Single cycle, fields valid alongside
        end
    end

endmodule

/* hdl/pcie_rx_engine.sv */
// ======================================================================
// PCIe endpoint receive engine, top level
// Beat decoder, control FSM, completion request and write registers
// ======================================================================

`timescale 1ns/100ps

`include "pcie_rx_params.svh"

module pcie_rx_engine
    import pcie_rx_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic [`PCIE_RX_DATA_W-1:0] rx_tdata,
    input  logic [`PCIE_RX_USER_W-1:0] rx_tuser,
    input  logic                       rx_tlast,   // Core interface only, not decoded
    input  logic                       rx_tvalid,
    output logic                       rx_tready,
    input  logic                       compl_done,
    input  logic                       wr_busy,
    output logic                       req_compl,
    output logic                       req_compl_wd,
    output logic [2:0]                 req_tc,
    output logic                       req_td,
    output logic                       req_ep,
    output logic [1:0]                 req_attr,
    output logic [`PCIE_RX_LEN_W-1:0]  req_len,
    output logic [15:0]                req_rid,
    output logic [7:0]                 req_tag,
    output logic [`PCIE_RX_BE_W-1:0]   req_be,
    output logic [`PCIE_RX_ADDR_W-1:0] req_addr,
    output logic                       wr_en,
    output logic [`PCIE_RX_ADDR_W-1:0] wr_addr,
    output logic [`PCIE_RX_DW_W-1:0]   wr_data,
    output logic [`PCIE_RX_BE_W-1:0]   wr_be
);

    beat_kind_e                 beat_kind;
    logic [2:0]                 tc;
    logic                       td;
    logic                       ep;
    logic [1:0]                 attr;
    logic [`PCIE_RX_LEN_W-1:0]  len;
    logic [15:0]                rid;
    logic [7:0]                 tag;
    logic [`PCIE_RX_BE_W-1:0]   be;
    logic [`PCIE_RX_ADDR_W-1:0] addr;
    logic [`PCIE_RX_DW_W-1:0]   wdata;
    logic                       hdr_load;
    logic                       rd_issue;
    logic                       wr_issue;
    logic                       cont_beat;

    tlp_hdr_decode u_decode (
        .rx_tdata (rx_tdata),  .rx_tuser (rx_tuser), .cont_beat (cont_beat),
        .beat_kind(beat_kind), .tc (tc),  .td (td),  .ep (ep),  .attr (attr),
        .len (len), .rid (rid), .tag (tag), .be (be), .addr (addr), .wdata (wdata)
    );

    rx_ctrl u_ctrl (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .rx_tvalid (rx_tvalid),
        .beat_kind (beat_kind), .wr_busy (wr_busy), .compl_done (compl_done),
        .rx_tready (rx_tready), .hdr_load (hdr_load), .rd_issue (rd_issue),
        .wr_issue (wr_issue), .cont_beat (cont_beat)
    );

    cpl_req_reg u_cpl (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .hdr_load (hdr_load), .rd_issue (rd_issue),
        .tc (tc), .td (td), .ep (ep), .attr (attr), .len (len), .rid (rid),
        .tag (tag), .be (be), .addr (addr),
        .req_compl (req_compl), .req_compl_wd (req_compl_wd), .req_tc (req_tc),
        .req_td (req_td), .req_ep (req_ep), .req_attr (req_attr), .req_len (req_len),
        .req_rid (req_rid), .req_tag (req_tag), .req_be (req_be), .req_addr (req_addr)
    );

    mem_wr_reg u_wr (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .hdr_load (hdr_load), .wr_issue (wr_issue),
        .be (be), .addr (addr), .wdata (wdata),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data), .wr_be (wr_be)
    );

endmodule

/* sim/tb_pcie_rx_engine.sv */
// ======================================================================
// Testbench for the PCIe receive engine
// Random 32-bit memory TLPs, reference model, output monitor,
// write sink and completion engine responder, cycle timeout
// ======================================================================

`timescale 1ns/100ps

`include "pcie_rx_params.svh"

module tb_pcie_rx_engine;

    localparam int NUM_TLP     = 60;
    localparam int MAX_TLP_CYC = 30;
    localparam int TIMEOUT_CYC = NUM_TLP * MAX_TLP_CYC + 200;   // Reset and drain margin

    typedef struct packed {
        logic [6:0]                op;
        logic [`PCIE_RX_LEN_W-1:0] len;
        logic [2:0]                tc;
        logic                      td;
        logic                      ep;
        logic [1:0]                attr;
        logic [15:0]               rid;
        logic [7:0]                tag;
        logic [`PCIE_RX_BE_W-1:0]  be;
        logic [31:0]               dw2;
        logic [31:0]               data;
        logic                      mid;   // Start in lane 2
    } tlp_desc_t;

    typedef struct packed {
        logic                       valid;
        logic                       is_rd;
        logic [2:0]                 tc;
        logic                       td;
        logic                       ep;
        logic [1:0]                 attr;
        logic [`PCIE_RX_LEN_W-1:0]  len;
        logic [15:0]                rid;
        logic [7:0]                 tag;
        logic [`PCIE_RX_BE_W-1:0]   be;
        logic [`PCIE_RX_ADDR_W-1:0] addr;
        logic [31:0]                data;
    } exp_rec_t;

    logic                       i_clk;
    logic                       i_rst_n;
    logic [`PCIE_RX_DATA_W-1:0] rx_tdata;
    logic [`PCIE_RX_USER_W-1:0] rx_tuser;
    logic                       rx_tlast;
    logic                       rx_tvalid;
    logic                       rx_tready;
    logic                       compl_done;
    logic                       wr_busy;
    logic                       req_compl;
    logic                       req_compl_wd;
    logic [2:0]                 req_tc;
    logic                       req_td;
    logic                       req_ep;
    logic [1:0]                 req_attr;
    logic [`PCIE_RX_LEN_W-1:0]  req_len;
    logic [15:0]                req_rid;
    logic [7:0]                 req_tag;
    logic [`PCIE_RX_BE_W-1:0]   req_be;
    logic [`PCIE_RX_ADDR_W-1:0] req_addr;
    logic                       wr_en;
    logic [`PCIE_RX_ADDR_W-1:0] wr_addr;
    logic [`PCIE_RX_DW_W-1:0]   wr_data;
    logic [`PCIE_RX_BE_W-1:0]   wr_be;

    logic [31:0] stim_rng = 32'h70db1f3d;
    logic [31:0] resp_rng = ~32'h70db1f3d;   // Second stream from the same seed
    exp_rec_t    exp_q[$];
    logic [1:0]  waiting = 2'd0;             // 0 none, 1 write, 2 read
    logic        armed   = 1'b0;
    int          n_wr    = 0;
    int          n_rd    = 0;
    int          n_drop  = 0;
    int          cycle_cnt = 0;

    pcie_rx_engine dut0 (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .rx_tdata (rx_tdata), .rx_tuser (rx_tuser),
        .rx_tlast (rx_tlast), .rx_tvalid (rx_tvalid), .rx_tready (rx_tready),
        .compl_done (compl_done), .wr_busy (wr_busy),
        .req_compl (req_compl), .req_compl_wd (req_compl_wd), .req_tc (req_tc),
        .req_td (req_td), .req_ep (req_ep), .req_attr (req_attr), .req_len (req_len),
        .req_rid (req_rid), .req_tag (req_tag), .req_be (req_be), .req_addr (req_addr),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data), .wr_be (wr_be)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [31:0] next_resp();
        resp_rng = xorshift32(resp_rng);
        return resp_rng;
    endfunction

    // Expected output of one TLP from the header field rules
    function automatic exp_rec_t expected_output(input tlp_desc_t t);
        exp_rec_t r;
        r       = '0;
        r.valid = (t.op == 7'h00 || t.op == 7'h40) && t.len == `PCIE_RX_LEN_W'(1);
        r.is_rd = (t.op == 7'h00);
        r.tc    = t.tc;
        r.td    = t.td;
        r.ep    = t.ep;
        r.attr  = t.attr;
        r.len   = t.len;
        r.rid   = t.rid;
        r.tag   = t.tag;
        r.be    = t.be;
        r.addr  = t.dw2[`PCIE_RX_ADDR_W+1:2];   // Dword address
        r.data  = t.data;
        return r;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else
            stop_on_error($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                    $time, name, got, want));
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        repeat (n) next_cycle();
    endtask

    // Holds the beat until an edge samples ready high
    task automatic send_beat(input logic [`PCIE_RX_DATA_W-1:0] data,
                             input logic [`PCIE_RX_USER_W-1:0] user, input logic last);
        logic rdy;
        rx_tdata  = data;
        rx_tuser  = user;
        rx_tlast  = last;
        rx_tvalid = 1'b1;
        do begin
            rdy = rx_tready;
            next_cycle();
        end while (!rdy);
        rx_tvalid = 1'b0;
    endtask

    task automatic send_tlp();
        tlp_desc_t                  t;
        exp_rec_t                   rec;
        logic [31:0]                r;
        logic [31:0]                dw0;
        logic [31:0]                dw1;
        logic [`PCIE_RX_USER_W-1:0] usr;
        int                         sel;
        sel    = next_stim() % 8;   // 0-2 write, 3-5 read, 6 other opcode, 7 bad length
        r      = next_stim();
        t.op   = (sel < 3) ? 7'h40 : 7'h00;
        t.len  = `PCIE_RX_LEN_W'(1);
        if (sel == 6)
            t.op = (r[6:0] == 7'h00 || r[6:0] == 7'h40) ? 7'h4a : r[6:0];
        if (sel == 7) begin
            t.op  = r[7] ? 7'h40 : 7'h00;
            t.len = (r[17:8] == 10'd1) ? 10'd2 : r[17:8];
        end
        r      = next_stim();
        t.tc   = r[2:0];
        t.td   = r[3];
        t.ep   = r[4];
        t.attr = r[6:5];
        t.mid  = r[7];
        t.tag  = r[15:8];
        t.rid  = r[31:16];
        r      = next_stim();
        t.be   = r[7:0];
        t.dw2  = next_stim();
        t.data = next_stim();
        dw0 = {1'b0, t.op, 1'b0, t.tc, 4'b0, t.td, t.ep, t.attr, 2'b0, t.len};
        dw1 = {t.rid, t.tag, t.be};
        r   = next_stim();
        usr = r[`PCIE_RX_USER_W-1:0];
        usr[`PCIE_RX_SOF_BIT]     = 1'b1;
        usr[`PCIE_RX_SOF_MID_BIT] = t.mid;
        rec = expected_output(t);
        if (rec.valid)
            exp_q.push_back(rec);
        else
            n_drop++;
        idle_cycles(next_stim() % 4);
        if (!t.mid) begin
            send_beat({t.data, t.dw2, dw1, dw0}, usr, 1'b1);
        end else begin
            send_beat({dw1, dw0, next_stim(), next_stim()}, usr, 1'b0);
            idle_cycles(next_stim() % 4);   // Gap between the two beats
            r   = next_stim();
            usr = r[`PCIE_RX_USER_W-1:0];
            usr[`PCIE_RX_SOF_BIT]     = 1'b0;
            usr[`PCIE_RX_SOF_MID_BIT] = 1'b0;
            send_beat({next_stim(), next_stim(), t.data, t.dw2}, usr, 1'b1);
        end
    endtask

    initial begin : stimulus
        i_rst_n   = 1'b1;
        rx_tvalid = 1'b0;
        rx_tdata  = '0;
        rx_tuser  = '0;
        rx_tlast  = 1'b0;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b0;
        for (int i = 0; i < NUM_TLP; i++) send_tlp();
        idle_cycles(MAX_TLP_CYC);
        assert (exp_q.size() == 0 && waiting == 2'd0) else
            stop_on_error("An expected output pulse never appeared or ready never returned");
        assert (n_wr > 0 && n_rd > 0 && n_drop > 0) else
            stop_on_error("Random stimulus missed writes, reads or discards");
        $display("Checked %0d writes, %0d reads, %0d discards", n_wr, n_rd, n_drop);
        $display("All tests passed!");
        $finish;
    end

    // Write sink busy time and completion engine delay
    initial begin : responder
        int busy_cnt;
        int cpl_cnt;
        busy_cnt   = 0;
        cpl_cnt    = 0;
        wr_busy    = 1'b0;
        compl_done = 1'b0;
        forever begin
            next_cycle();
            if (wr_en)
                busy_cnt = next_resp() % 5;
            else if (busy_cnt > 0)
                busy_cnt--;
            if (req_compl)
                cpl_cnt = next_resp() % 5 + 1;
            compl_done = (cpl_cnt == 1);
            if (cpl_cnt > 0)
                cpl_cnt--;
            wr_busy = (busy_cnt != 0);
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge i_clk) begin : monitor
        exp_rec_t rec;
        if (i_rst_n || !armed) begin
            assert (!rx_tready && !wr_en && !req_compl) else
                stop_on_error("Outputs were active in reset or in the cycle after it");
            armed = !i_rst_n;
        end else begin
            if (wr_en || req_compl) begin
                assert (waiting == 2'd0 && exp_q.size() > 0) else
                    stop_on_error("Output pulse appeared with no request outstanding");
                rec = exp_q.pop_front();
                check_field("wr_en", wr_en, !rec.is_rd);
                check_field("req_compl", req_compl, rec.is_rd);
                check_field("req_compl_wd", req_compl_wd, rec.is_rd);
                if (rec.is_rd) begin
                    check_field("req_tc", req_tc, rec.tc);
                    check_field("req_td", req_td, rec.td);
                    check_field("req_ep", req_ep, rec.ep);
                    check_field("req_attr", req_attr, rec.attr);
                    check_field("req_len", req_len, rec.len);
                    check_field("req_rid", req_rid, rec.rid);
                    check_field("req_tag", req_tag, rec.tag);
                    check_field("req_be", req_be, rec.be);
                    check_field("req_addr", req_addr, rec.addr);
                    n_rd++;
                end else begin
                    check_field("wr_addr", wr_addr, rec.addr);
                    check_field("wr_data", wr_data, rec.data);
                    check_field("wr_be", wr_be, rec.be);
                    n_wr++;
                end
                waiting = rec.is_rd ? 2'd2 : 2'd1;
            end
            if (waiting != 2'd0) begin
                check_field("rx_tready", rx_tready, 0);
                // Next edge releases the FSM
                if ((waiting == 2'd1 && !wr_busy) || (waiting == 2'd2 && compl_done))
                    waiting = 2'd0;
            end else begin
                check_field("rx_tready", rx_tready, 1);
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYC)
            stop_on_error("Timeout, the run did not finish within the cycle limit");
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/pcie_tlp_pkg.sv
hdl/pcie_rx_pkg.sv
hdl/tlp_hdr_decode.sv
hdl/rx_ctrl.sv
hdl/cpl_req_reg.sv
hdl/mem_wr_reg.sv
hdl/pcie_rx_engine.sv
sim/tb_pcie_rx_engine.sv

/* Bender.yml */
package:
  name: pcie_rx_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pcie_tlp_pkg.sv
      - hdl/pcie_rx_pkg.sv
      - hdl/tlp_hdr_decode.sv
      - hdl/rx_ctrl.sv
      - hdl/cpl_req_reg.sv
      - hdl/mem_wr_reg.sv
      - hdl/pcie_rx_engine.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_pcie_rx_engine.sv
